//--- include/clk_mgmt_consts.svh
`ifndef CLK_MGMT_CONSTS_SVH
`define CLK_MGMT_CONSTS_SVH

// phase word, two's complement steps of the clock manager
`define PHASE_W       9     // phase word width
`define PHASE_MAX     255   // largest phase magnitude accepted

// latencies of the behavioral fabric
`define PS_LATENCY    4     // step pulse to ps_done
`define PROG_LATENCY  6     // go command to prog_done
`define LOCK_DELAY    8     // reset or reprogram to lock

// acknowledge supervision
`define ACK_TIMEOUT   64    // cycles before a wait is abandoned

`endif

//--- hw/clk_ctrl_pkg.sv
package clk_ctrl_pkg;

    // phase shift controller FSM states
    typedef enum logic [1:0] {
        IDLE     = 2'd0,  // waiting for a load
        STEP     = 2'd1,  // issue one step
        WAIT_ACK = 2'd2,  // step outstanding
        ABORT    = 2'd3   // ack never came
    } ps_state_e;

    // serial command codes of the synthesizer program port
    // first bit on the wire is bit 0, so both loads lead with a one
    typedef enum logic [1:0] {
        GO     = 2'b00,  // apply pending M and D
        LOAD_D = 2'b01,  // divider frame
        LOAD_M = 2'b11   // multiplier frame
    } prog_cmd_e;

endpackage

//--- hw/dcm_if_pkg.sv
package dcm_if_pkg;

    // step request into the phase shifting clock manager
    typedef struct packed {
        logic en;      // one cycle step strobe
        logic incdec;  // 1 = increment
    } ps_req_s;

    // serial program port of the synthesizer
    typedef struct packed {
        logic en;    // high for the whole frame
        logic data;  // serial bit, value LSB first
    } prog_req_s;

    // fabric status back to the controllers
    typedef struct packed {
        logic ps_done;     // step acknowledge pulse
        logic prog_done;   // reprogram acknowledge pulse
        logic adc_locked;  // adc manager locked and clock running
        logic gen_locked;  // synthesizer locked and clock running
    } fabric_status_s;

endpackage

//--- hw/ack_timeout_timer.sv
`timescale 1ns/1ps
`include "clk_mgmt_consts.svh"

module ack_timeout_timer (
    input  logic clk_usb,
    input  logic arst_n_i,
    input  logic start_i,    // begin a wait
    input  logic stop_i,     // ack arrived
    output logic expired_o   // one cycle pulse on timeout
);

    localparam int CNT_W = $clog2(`ACK_TIMEOUT + 1);

    logic [CNT_W-1:0] cnt;
    logic             running;

    always_ff @(posedge clk_usb or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt       <= '0;
            running   <= 1'b0;
            expired_o <= 1'b0;
        end else begin
            expired_o <= 1'b0;
            if (start_i) begin
                cnt     <= CNT_W'(`ACK_TIMEOUT);  // reload on every start
                running <= 1'b1;
            end else if (stop_i) begin
                running <= 1'b0;
            end else if (running) begin
                if (cnt == '0) begin
                    expired_o <= 1'b1;
                    running   <= 1'b0;
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end
        end
    end

endmodule

//--- hw/phase_shift_ctrl.sv
`timescale 1ns/1ps
`include "clk_mgmt_consts.svh"

module phase_shift_ctrl (
    input  logic                   clk_usb,
    input  logic                   arst_n_i,
    input  logic                   load_i,         // one cycle load strobe
    input  logic [`PHASE_W-1:0]    value_i,        // requested phase
    output logic [`PHASE_W-1:0]    value_o,        // actual phase
    output logic                   done_o,         // level, high when settled
    output logic                   err_o,          // ack timeout seen
    output dcm_if_pkg::ps_req_s    ps_req_o,
    input  logic                   ps_done_i,
    output logic                   tmr_start_o,
    input  logic                   tmr_expired_i
);

    localparam logic signed [`PHASE_W-1:0] P_MAX = `PHASE_W'(`PHASE_MAX);
    localparam logic signed [`PHASE_W-1:0] P_MIN = `PHASE_W'(-`PHASE_MAX);

    clk_ctrl_pkg::ps_state_e       state;
    logic signed [`PHASE_W-1:0]    req_s;        // request seen as signed
    logic signed [`PHASE_W-1:0]    req_clamped;  // request within range
    logic signed [`PHASE_W-1:0]    target;       // latched goal
    logic [`PHASE_W-1:0]           value_next;   // actual after this step

    assign req_s = $signed(value_i);

    always_comb begin
        req_clamped = req_s;
        if (req_s > P_MAX) begin
            req_clamped = P_MAX;  // clip high side
        end else if (req_s < P_MIN) begin
            req_clamped = P_MIN;  // clip low side
        end
    end

    assign value_next  = ps_req_o.incdec ? value_o + 1'b1 : value_o - 1'b1;
    assign tmr_start_o = ps_req_o.en;  // supervise every step from its strobe

    always_ff @(posedge clk_usb or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state    <= clk_ctrl_pkg::IDLE;
            target   <= '0;
            value_o  <= '0;
            done_o   <= 1'b1;
            err_o    <= 1'b0;
            ps_req_o <= '0;
        end else begin
            ps_req_o.en <= 1'b0;  // strobe by default low
            case (state)
                clk_ctrl_pkg::IDLE: begin
                    if (load_i) begin
                        target <= req_clamped;
                        err_o  <= 1'b0;  // new load clears old error
                        if (req_clamped != value_o) begin
                            done_o <= 1'b0;
                            state  <= clk_ctrl_pkg::STEP;
                        end
                    end
                end
                clk_ctrl_pkg::STEP: begin
                    ps_req_o.en     <= 1'b1;
                    ps_req_o.incdec <= target > $signed(value_o);  // direction toward goal
                    state           <= clk_ctrl_pkg::WAIT_ACK;
                end
                clk_ctrl_pkg::WAIT_ACK: begin
                    if (ps_done_i) begin
                        value_o <= value_next;  // count the step the fabric took
                        if (value_next == target) begin
                            done_o <= 1'b1;
                            state  <= clk_ctrl_pkg::IDLE;
                        end else begin
                            state <= clk_ctrl_pkg::STEP;
                        end
                    end else if (tmr_expired_i) begin
                        state <= clk_ctrl_pkg::ABORT;
                    end
                end
                clk_ctrl_pkg::ABORT: begin
                    done_o <= 1'b1;  // give up, actual stays where it got
                    err_o  <= 1'b1;
                    state  <= clk_ctrl_pkg::IDLE;
                end
                default: state <= clk_ctrl_pkg::IDLE;
            endcase
        end
    end

endmodule

//--- hw/clkgen_prog_serializer.sv
`timescale 1ns/1ps

module clkgen_prog_serializer (
    input  logic                   clk_usb,
    input  logic                   arst_n_i,
    input  logic                   load_i,      // one cycle load strobe
    input  logic [7:0]             mul_i,       // M, sampled with load
    input  logic [7:0]             div_i,       // D, sampled with load
    output logic                   done_o,      // level, high when idle
    output logic                   err_o,       // prog_done never came
    output dcm_if_pkg::prog_req_s  prog_req_o,
    input  logic                   prog_done_i,
    output logic                   tmr_start_o,
    input  logic                   tmr_expired_i
);

    clk_ctrl_pkg::prog_cmd_e  cmd;       // command now on the wire
    logic        sending;                // frame bits going out
    logic        gap;                    // idle cycle between frames
    logic [3:0]  bit_cnt;                // bit within frame
    logic        last_bit;
    logic        accept;
    logic [9:0]  shreg;                  // {value minus one, code}
    logic [7:0]  mul_m1;                 // M frame held until needed

    assign accept   = load_i && done_o;  // loads while busy are dropped
    assign last_bit = (cmd == clk_ctrl_pkg::GO) || (bit_cnt == 4'd9);

    assign prog_req_o.en   = sending;
    assign prog_req_o.data = shreg[0];  // LSB first
    assign tmr_start_o     = sending && (cmd == clk_ctrl_pkg::GO);

    always_ff @(posedge clk_usb or negedge arst_n_i) begin
        if (!arst_n_i) begin
            done_o  <= 1'b1;
            err_o   <= 1'b0;
            sending <= 1'b0;
            gap     <= 1'b0;
            bit_cnt <= '0;
            cmd     <= clk_ctrl_pkg::GO;
        end else if (accept) begin
            done_o  <= 1'b0;
            err_o   <= 1'b0;
            sending <= 1'b1;
            bit_cnt <= '0;
            cmd     <= clk_ctrl_pkg::LOAD_D;  // divider goes first
        end else if (sending) begin
            bit_cnt <= bit_cnt + 4'd1;
            if (last_bit) begin
                sending <= 1'b0;
                gap     <= (cmd != clk_ctrl_pkg::GO);  // no gap after go
            end
        end else if (gap) begin
            gap     <= 1'b0;
            sending <= 1'b1;
            bit_cnt <= '0;
            cmd     <= (cmd == clk_ctrl_pkg::LOAD_D) ? clk_ctrl_pkg::LOAD_M : clk_ctrl_pkg::GO;
        end else if (!done_o && (prog_done_i || tmr_expired_i)) begin
            done_o <= 1'b1;  // wait after go is over
            err_o  <= !prog_done_i;
        end
    end

    // frame data path
    always_ff @(posedge clk_usb) begin
        if (accept) begin
            shreg  <= {div_i - 8'd1, clk_ctrl_pkg::LOAD_D};
            mul_m1 <= mul_i - 8'd1;
        end else if (sending) begin
            shreg <= {1'b0, shreg[9:1]};
        end else if (gap) begin
            shreg <= (cmd == clk_ctrl_pkg::LOAD_D) ? {mul_m1, clk_ctrl_pkg::LOAD_M} : '0;
        end
    end

endmodule

//--- hw/clk_fabric_model.sv
`timescale 1ns/1ps
`include "clk_mgmt_consts.svh"

module clk_fabric_model (
    input  logic                        clk_usb,
    input  logic                        clk_ext_i,
    input  logic                        arst_n_i,
    input  logic [2:0]                  clkadc_source_i,
    input  logic                        clkgen_source_i,
    input  dcm_if_pkg::ps_req_s         ps_req_i,
    input  dcm_if_pkg::prog_req_s       prog_req_i,
    output dcm_if_pkg::fabric_status_s  status_o,
    output logic [7:0]                  mul_o,         // applied M
    output logic [7:0]                  div_o,         // applied D
    output logic                        adc_clk_o,
    output logic                        target_clk_o,
    output logic                        systemsample_clk_o
);

    localparam int LOCK_W = $clog2(`LOCK_DELAY + 1);

    logic clkgenfx_in;      // synthesizer input
    logic dcm_clk_in;       // phase manager input
    logic adc_clk_1x;
    logic adc_clk_4x;       // no real multiply here
    logic out_from_dcmmux;
    logic adc_clk_sample;

    logic [`PS_LATENCY-1:0]   ps_pipe;    // step ack delay line
    logic [`PROG_LATENCY-1:0] prog_pipe;  // go to prog_done delay line
    logic [3:0]               rx_cnt;     // bits seen in this frame
    logic [8:0]               rx_bits;    // frame bits so far
    logic [9:0]               frame;
    logic                     frame_done;
    logic                     go_now;
    logic [7:0]               m_pend;     // M minus one, not yet applied
    logic [7:0]               d_pend;

    logic [1:0][LOCK_W-1:0]   lock_cnt;   // [0] adc, [1] gen
    logic [1:0]               mon_clk;
    logic [1:0]               mon_tog;
    logic [1:0][2:0]          mon_sync;
    logic [1:0][2:0]          idle_cnt;
    logic [1:0]               stopped;    // input clock not toggling

    // clock multiplexers
    assign clkgenfx_in     = clkgen_source_i ? clk_ext_i : clk_usb;
    assign target_clk_o    = clkgenfx_in;  // synthesizer output follows input
    assign dcm_clk_in      = clkadc_source_i[2] ? clk_ext_i : target_clk_o;
    assign adc_clk_1x      = dcm_clk_in;
    assign adc_clk_4x      = dcm_clk_in;
    assign out_from_dcmmux = clkadc_source_i[1] ? adc_clk_1x : adc_clk_4x;
    assign adc_clk_sample  = clkadc_source_i[0] ? clk_ext_i : out_from_dcmmux;
    assign adc_clk_o          = adc_clk_sample;
    assign systemsample_clk_o = adc_clk_sample;

    // serial frames, both load codes start with a one so a leading zero is go
    assign go_now     = prog_req_i.en && (rx_cnt == 4'd0) && !prog_req_i.data;
    assign frame_done = prog_req_i.en && (rx_cnt == 4'd9);
    assign frame      = {prog_req_i.data, rx_bits};

    always_ff @(posedge clk_usb or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ps_pipe   <= '0;
            prog_pipe <= '0;
            rx_cnt    <= '0;
            mul_o     <= 8'd1;
            div_o     <= 8'd1;
            lock_cnt  <= {2{LOCK_W'(`LOCK_DELAY)}};
        end else begin
            ps_pipe   <= {ps_pipe[`PS_LATENCY-2:0], ps_req_i.en};
            prog_pipe <= {prog_pipe[`PROG_LATENCY-2:0], go_now};
            rx_cnt    <= prog_req_i.en ? rx_cnt + 4'd1 : 4'd0;
            if (prog_pipe[`PROG_LATENCY-1]) begin
                mul_o <= m_pend + 8'd1;  // new ratio visible at prog_done
                div_o <= d_pend + 8'd1;
            end
            if (lock_cnt[0] != '0) begin
                lock_cnt[0] <= lock_cnt[0] - 1'b1;
            end
            if (go_now) begin
                lock_cnt[1] <= LOCK_W'(`LOCK_DELAY);  // synthesizer relocks
            end else if (lock_cnt[1] != '0) begin
                lock_cnt[1] <= lock_cnt[1] - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_usb) begin
        if (prog_req_i.en) begin
            rx_bits <= {prog_req_i.data, rx_bits[8:1]};
        end
        if (frame_done && (frame[1:0] == clk_ctrl_pkg::LOAD_D)) begin
            d_pend <= frame[9:2];
        end else if (frame_done && (frame[1:0] == clk_ctrl_pkg::LOAD_M)) begin
            m_pend <= frame[9:2];
        end
    end

    // input clock monitors, toggle in source domain and watch it from clk_usb
    assign mon_clk = {clkgenfx_in, dcm_clk_in};

    for (genvar i = 0; i < 2; i++) begin : g_mon
        always_ff @(posedge mon_clk[i] or negedge arst_n_i) begin
            if (!arst_n_i) begin
                mon_tog[i] <= 1'b0;
            end else begin
                mon_tog[i] <= ~mon_tog[i];
            end
        end

        always_ff @(posedge clk_usb or negedge arst_n_i) begin
            if (!arst_n_i) begin
                mon_sync[i] <= '0;
                idle_cnt[i] <= '0;
            end else begin
                mon_sync[i] <= {mon_sync[i][1:0], mon_tog[i]};
                if (mon_sync[i][2] != mon_sync[i][1]) begin
                    idle_cnt[i] <= '0;  // clock alive
                end else if (!stopped[i]) begin
                    idle_cnt[i] <= idle_cnt[i] + 3'd1;
                end
            end
        end

        assign stopped[i] = &idle_cnt[i];
    end

    assign status_o.ps_done    = ps_pipe[`PS_LATENCY-1];
    assign status_o.prog_done  = prog_pipe[`PROG_LATENCY-1];
    assign status_o.adc_locked = (lock_cnt[0] == '0) && !stopped[0];
    assign status_o.gen_locked = (lock_cnt[1] == '0) && !stopped[1];

endmodule

//--- hw/clk_mgmt_top.sv
`timescale 1ns/1ps
`include "clk_mgmt_consts.svh"

module clk_mgmt_top (
    input  logic                clk_usb,             // control clock
    input  logic                clk_ext_i,           // external clock
    input  logic                arst_n_i,
    input  logic [2:0]          clkadc_source_i,
    input  logic                clkgen_source_i,
    input  logic [7:0]          clkgen_mul_i,
    input  logic [7:0]          clkgen_div_i,
    input  logic                clkgen_load_i,
    output logic                clkgen_done_o,
    output logic                clkgen_err_o,
    output logic [7:0]          clkgen_mul_o,
    output logic [7:0]          clkgen_div_o,
    input  logic [`PHASE_W-1:0] phase_requested_i,
    input  logic                phase_load_i,
    output logic [`PHASE_W-1:0] phase_actual_o,
    output logic                phase_done_o,
    output logic                phase_err_o,
    output logic                adc_locked_o,
    output logic                gen_locked_o,
    output logic                adc_clk_o,
    output logic                target_clk_o,
    output logic                systemsample_clk_o
);

    dcm_if_pkg::ps_req_s         ps_req;
    dcm_if_pkg::prog_req_s       prog_req;
    dcm_if_pkg::fabric_status_s  status;
    logic                        ps_tmr_start;
    logic                        ps_tmr_expired;
    logic                        prog_tmr_start;
    logic                        prog_tmr_expired;

    assign adc_locked_o = status.adc_locked;
    assign gen_locked_o = status.gen_locked;

    phase_shift_ctrl phase_shift_ctrl_inst (
        .clk_usb       (clk_usb),
        .arst_n_i      (arst_n_i),
        .load_i        (phase_load_i),
        .value_i       (phase_requested_i),
        .value_o       (phase_actual_o),
        .done_o        (phase_done_o),
        .err_o         (phase_err_o),
        .ps_req_o      (ps_req),
        .ps_done_i     (status.ps_done),
        .tmr_start_o   (ps_tmr_start),
        .tmr_expired_i (ps_tmr_expired)
    );

    ack_timeout_timer timer_ps (
        .clk_usb   (clk_usb),
        .arst_n_i  (arst_n_i),
        .start_i   (ps_tmr_start),
        .stop_i    (status.ps_done),    // step ack ends the wait
        .expired_o (ps_tmr_expired)
    );

    clkgen_prog_serializer clkgen_prog_serializer_inst (
        .clk_usb       (clk_usb),
        .arst_n_i      (arst_n_i),
        .load_i        (clkgen_load_i),
        .mul_i         (clkgen_mul_i),
        .div_i         (clkgen_div_i),
        .done_o        (clkgen_done_o),
        .err_o         (clkgen_err_o),
        .prog_req_o    (prog_req),
        .prog_done_i   (status.prog_done),
        .tmr_start_o   (prog_tmr_start),
        .tmr_expired_i (prog_tmr_expired)
    );

    ack_timeout_timer timer_prog (
        .clk_usb   (clk_usb),
        .arst_n_i  (arst_n_i),
        .start_i   (prog_tmr_start),
        .stop_i    (status.prog_done),  // program ack ends the wait
        .expired_o (prog_tmr_expired)
    );

    clk_fabric_model clk_fabric_model_inst (
        .clk_usb            (clk_usb),
        .clk_ext_i          (clk_ext_i),
        .arst_n_i           (arst_n_i),
        .clkadc_source_i    (clkadc_source_i),
        .clkgen_source_i    (clkgen_source_i),
        .ps_req_i           (ps_req),
        .prog_req_i         (prog_req),
        .status_o           (status),
        .mul_o              (clkgen_mul_o),
        .div_o              (clkgen_div_o),
        .adc_clk_o          (adc_clk_o),
        .target_clk_o       (target_clk_o),
        .systemsample_clk_o (systemsample_clk_o)
    );

endmodule

//--- testbench/tb_clk_mgmt.sv
`timescale 1ns/1ps
`include "clk_mgmt_consts.svh"

module tb_clk_mgmt;

    localparam int PHASE_TMO  = (2 * `PHASE_MAX + 1) * (`PS_LATENCY + 2) + 256;  // full swing
    localparam int CLKGEN_TMO = 24 + `PROG_LATENCY + `ACK_TIMEOUT + 16;
    localparam int LOCK_TMO   = `LOCK_DELAY + 2;

    logic                clk_usb;
    logic                clk_ext_i;
    logic                arst_n_i;
    logic [2:0]          clkadc_source_i;
    logic                clkgen_source_i;
    logic [7:0]          clkgen_mul_i;
    logic [7:0]          clkgen_div_i;
    logic                clkgen_load_i;
    logic                clkgen_done_o;
    logic                clkgen_err_o;
    logic [7:0]          clkgen_mul_o;
    logic [7:0]          clkgen_div_o;
    logic [`PHASE_W-1:0] phase_requested_i;
    logic                phase_load_i;
    logic [`PHASE_W-1:0] phase_actual_o;
    logic                phase_done_o;
    logic                phase_err_o;
    logic                adc_locked_o;
    logic                gen_locked_o;
    logic                adc_clk_o;
    logic                target_clk_o;
    logic                systemsample_clk_o;

    int                  value_errs;      // wrong values seen
    int                  timeout_errs;    // waits that ran out
    int                  file_errs;       // golden file problems
    int                  cmd_count;       // commands executed
    int                  fd;
    int                  n_fields;
    int                  gap;
    logic [8*128-1:0]    line_buf;        // one golden line
    logic [63:0]         op_word;         // opcode text
    logic [31:0]         f_a;
    logic [31:0]         f_b;
    logic [31:0]         f_c;
    logic [31:0]         f_d;
    logic                gen_lock_dropped;  // seen low during reprogram

    clk_mgmt_top clk_mgmt_top_inst (.*);

    initial begin
        clk_usb = 1'b0;
        forever #5 clk_usb = ~clk_usb;  // 100 MHz control clock
    end

    initial begin
        clk_ext_i = 1'b0;
        forever #7 clk_ext_i = ~clk_ext_i;  // external clock with 14 ns period
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            value_errs++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s did not rise in time at %0t", what, $time);
        timeout_errs++;
    endtask

    task automatic wait_phase_done();
        int n;
        n = 0;
        while (!phase_done_o && n < PHASE_TMO) begin
            @(negedge clk_usb);
            n++;
        end
        if (!phase_done_o) report_timeout("phase_done_o");
    endtask

    task automatic wait_clkgen_done();
        int n;
        n = 0;
        while (!clkgen_done_o && n < CLKGEN_TMO) begin
            @(negedge clk_usb);
            if (!gen_locked_o) gen_lock_dropped = 1'b1;  // relock window
            n++;
        end
        if (!clkgen_done_o) report_timeout("clkgen_done_o");
    endtask

    task automatic wait_gen_locked();
        int n;
        n = 0;
        while (!gen_locked_o && n < LOCK_TMO) begin
            @(negedge clk_usb);
            n++;
        end
        if (!gen_locked_o) report_timeout("gen_locked_o");
    endtask

    task automatic wait_adc_locked();
        int n;
        n = 0;
        while (!adc_locked_o && n < LOCK_TMO - 1) begin  // one cycle spent on reset values
            @(negedge clk_usb);
            n++;
        end
        if (!adc_locked_o) report_timeout("adc_locked_o");
    endtask

    task automatic run_phase(input logic [`PHASE_W-1:0] req, input logic busy,
                             input logic [`PHASE_W-1:0] busy_req,
                             input logic [`PHASE_W-1:0] exp);
        logic [`PHASE_W-1:0] prev;
        prev              = phase_actual_o;
        phase_requested_i = req;
        phase_load_i      = 1'b1;
        @(negedge clk_usb);
        phase_load_i = 1'b0;
        compare_value("phase_done_o", phase_done_o, exp == prev);  // stays high only if no move
        if (busy) begin
            @(negedge clk_usb);
            if (phase_done_o) begin
                $display("busy phase load could not be issued, sequence already finished");
                value_errs++;
            end
            phase_requested_i = busy_req;  // must be dropped by the DUT
            phase_load_i      = 1'b1;
            @(negedge clk_usb);
            phase_load_i = 1'b0;
        end
        wait_phase_done();
        compare_value("phase_actual_o", phase_actual_o, exp);
        compare_value("phase_err_o", phase_err_o, 1'b0);
    endtask

    task automatic run_clkgen(input logic [7:0] mul, input logic [7:0] div,
                              input logic [7:0] exp_mul, input logic [7:0] exp_div);
        clkgen_mul_i  = mul;
        clkgen_div_i  = div;
        clkgen_load_i = 1'b1;
        @(negedge clk_usb);
        clkgen_load_i    = 1'b0;
        clkgen_mul_i     = ~mul;  // only the load cycle may count
        clkgen_div_i     = ~div;
        gen_lock_dropped = 1'b0;
        compare_value("clkgen_done_o", clkgen_done_o, 1'b0);
        wait_clkgen_done();
        if (timeout_errs == 0) begin
            wait_gen_locked();
            compare_value("clkgen_mul_o", clkgen_mul_o, exp_mul);
            compare_value("clkgen_div_o", clkgen_div_o, exp_div);
            compare_value("clkgen_err_o", clkgen_err_o, 1'b0);
            if (!gen_lock_dropped) begin
                $display("gen_locked_o did not drop while the synthesizer was reprogrammed");
                value_errs++;
            end
        end
    endtask

    task automatic run_src(input logic [2:0] adc_src, input logic gen_src,
                           input logic exp_t_ext, input logic exp_a_ext);
        int   k;
        logic exp_t;
        logic exp_a;
        clkadc_source_i = adc_src;
        clkgen_source_i = gen_src;
        @(negedge clk_usb);
        #0.5;  // off the integer grid so never on a clock edge
        for (k = 0; k < 40; k++) begin
            exp_t = exp_t_ext ? clk_ext_i : clk_usb;
            exp_a = exp_a_ext ? clk_ext_i : clk_usb;
            compare_value("target_clk_o", target_clk_o, exp_t);
            compare_value("adc_clk_o", adc_clk_o, exp_a);
            compare_value("systemsample_clk_o", systemsample_clk_o, exp_a);
            #1;
        end
        @(negedge clk_usb);  // back on the drive edge
    endtask

    initial begin
        value_errs        = 0;
        timeout_errs      = 0;
        file_errs         = 0;
        cmd_count         = 0;
        void'($urandom(32'haf37ecbe));
        arst_n_i          = 1'b0;
        clkadc_source_i   = 3'd0;
        clkgen_source_i   = 1'b0;
        clkgen_mul_i      = 8'd0;
        clkgen_div_i      = 8'd0;
        clkgen_load_i     = 1'b0;
        phase_requested_i = '0;
        phase_load_i      = 1'b0;
        repeat (2) @(negedge clk_usb);
        arst_n_i = 1'b1;
        @(negedge clk_usb);
        compare_value("phase_done_o", phase_done_o, 1'b1);
        compare_value("clkgen_done_o", clkgen_done_o, 1'b1);
        compare_value("phase_actual_o", phase_actual_o, 0);
        compare_value("clkgen_mul_o", clkgen_mul_o, 1);
        compare_value("clkgen_div_o", clkgen_div_o, 1);
        compare_value("phase_err_o", phase_err_o, 1'b0);
        compare_value("clkgen_err_o", clkgen_err_o, 1'b0);
        compare_value("adc_locked_o", adc_locked_o, 1'b0);  // lock delay still running
        compare_value("gen_locked_o", gen_locked_o, 1'b0);
        wait_adc_locked();

        fd = $fopen("testbench/clk_mgmt_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open golden file testbench/clk_mgmt_golden.txt");
            file_errs++;
        end else begin
            while (timeout_errs == 0 && $fgets(line_buf, fd) != 0) begin
                op_word  = '0;
                n_fields = $sscanf(line_buf, "%s %h %h %h %h", op_word, f_a, f_b, f_c, f_d);
                if (n_fields <= 0 || op_word == "#") begin
                    continue;  // blank or comment line
                end
                if (n_fields != 5) begin
                    $display("golden line has %0d fields, five expected", n_fields);
                    file_errs++;
                end else if (op_word == "PHASE") begin
                    run_phase(f_a[`PHASE_W-1:0], f_b[0], f_c[`PHASE_W-1:0], f_d[`PHASE_W-1:0]);
                    cmd_count++;
                end else if (op_word == "CLKGEN") begin
                    run_clkgen(f_a[7:0], f_b[7:0], f_c[7:0], f_d[7:0]);
                    cmd_count++;
                end else if (op_word == "SRC") begin
                    run_src(f_a[2:0], f_b[0], f_c[0], f_d[0]);
                    cmd_count++;
                end else begin
                    $display("unknown opcode in golden file");
                    file_errs++;
                end
                gap = $urandom % 4;  // idle cycles between commands
                repeat (gap) @(negedge clk_usb);
            end
            $fclose(fd);
            if (cmd_count == 0 && timeout_errs == 0) begin
                $display("golden file held no commands");
                file_errs++;
            end
        end

        $display("errors: value %0d, timeout %0d, file %0d", value_errs, timeout_errs, file_errs);
        if (value_errs + timeout_errs + file_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- testbench/clk_mgmt_golden.txt
# all fields hex; PHASE: request busy_flag busy_request expected_actual
# CLKGEN: mul div expected_mul expected_div; SRC: clkadc_source clkgen_source target_ext adc_ext
PHASE 010 0 000 010
PHASE 1f6 0 000 1f6
PHASE 0ff 0 000 0ff
PHASE 100 0 000 101
PHASE 101 0 000 101
PHASE 005 1 030 005
PHASE 000 0 000 000
CLKGEN 05 03 05 03
CLKGEN ff 01 ff 01
CLKGEN 01 08 01 08
SRC 0 0 0 0
SRC 1 0 0 1
SRC 2 0 0 0
SRC 4 0 0 1
SRC 0 1 1 1
SRC 6 1 1 1
SRC 2 1 1 1
SRC 0 0 0 0

//--- sim.f
+incdir+include
hw/clk_ctrl_pkg.sv
hw/dcm_if_pkg.sv
hw/ack_timeout_timer.sv
hw/phase_shift_ctrl.sv
hw/clkgen_prog_serializer.sv
hw/clk_fabric_model.sv
hw/clk_mgmt_top.sv
testbench/tb_clk_mgmt.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run from the project root, judge by the log
LOG=sim.log
rm -f "$LOG"
verilator --binary --timing -Wno-fatal --top-module tb_clk_mgmt -f sim.f -o tb_clk_mgmt \
    && ./obj_dir/tb_clk_mgmt > "$LOG" 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }
cat "$LOG"
grep -q "Verification failed" "$LOG" && { echo "simulation reported failure"; exit 1; }
grep -q "Verification passed" "$LOG" || { echo "no result in $LOG"; exit 1; }
exit 0
